// ==== all.f ====
verilog/ics_pkg.sv
verilog/ram_port.sv
verilog/address_decoder.sv
verilog/bus_arbiter.sv
verilog/cpu_ram.sv
verilog/mmio_regs.sv
verilog/boot_loader.sv
verilog/ics_core.sv
testbench/tb_ics_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator and run it, exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f all.f --top-module tb_ics_core \
    --Mdir obj_dir -o sim_ics_core &&
./obj_dir/sim_ics_core ||
{ echo "simulation did not complete cleanly"; exit 1; }

// ==== testbench/tb_ics_core.sv ====
//////////////////////////////////////////////////
// seeded random traffic checked against a bus model
// cpu ram traffic stays inside the boot window
// operands are written before the first product read
//////////////////////////////////////////////////

module tb_ics_core;

    import ics_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DELAY = 10;
    localparam int RESET_CYCLES = 10;
    localparam int BOOT_WORDS = 64;
    localparam int ARB_WORDS = 32;
    localparam int MAX_GAP = 3;
    localparam int RAM_OPS = 200;
    localparam int ARB_OPS = 64;
    localparam int DSP_ROUNDS = 24;
    localparam int STATUS_ROUNDS = 16;
    localparam int UNMAPPED_OPS = 16;
    // access and ready cycle plus a spare, loader stalls counted apart
    localparam int ACCESS_CYCLES = 3;
    localparam int STREAM_CYCLES = (BOOT_WORDS + ARB_WORDS) * (MAX_GAP + 1) + 4;
    localparam int ACCESS_COUNT = 2 * BOOT_WORDS + RAM_OPS + ARB_OPS
                                + 3 * DSP_ROUNDS + 2 * STATUS_ROUNDS + UNMAPPED_OPS;
    localparam int MAX_CYCLES = RESET_CYCLES + STREAM_CYCLES
                              + ACCESS_COUNT * ACCESS_CYCLES + ARB_WORDS + 100;

    logic                  vdp_clk;
    logic                  vdp_reset;
    logic                  cpu_valid;
    logic [ADDR_WIDTH-1:0] cpu_address;
    logic [3:0]            cpu_wstrb;
    logic [31:0]           cpu_write_data;
    logic [31:0]           cpu_read_data;
    logic                  cpu_ready;
    logic                  boot_valid;
    logic [31:0]           boot_data;
    logic                  boot_last;
    logic                  loader_busy;
    logic                  led_r;
    logic                  led_b;

    // reference model state
    logic [31:0]        ram_model [RAM_WORDS];
    logic signed [15:0] model_a;
    logic signed [15:0] model_b;
    logic [1:0]         model_status;

    integer seed = 66;
    int     cycle_count = 0;

    ics_core u_ics_core (
        .vdp_clk        (vdp_clk),
        .vdp_reset      (vdp_reset),
        .cpu_valid      (cpu_valid),
        .cpu_address    (cpu_address),
        .cpu_wstrb      (cpu_wstrb),
        .cpu_write_data (cpu_write_data),
        .cpu_read_data  (cpu_read_data),
        .cpu_ready      (cpu_ready),
        .boot_valid     (boot_valid),
        .boot_data      (boot_data),
        .boot_last      (boot_last),
        .loader_busy    (loader_busy),
        .led_r          (led_r),
        .led_b          (led_b)
    );

    always #(CLK_PERIOD / 2) vdp_clk = ~vdp_clk;

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "simulation stopped on error");
    endtask

    always @(posedge vdp_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    task automatic compare_word(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_leds(input logic [1:0] expected);
        if ({led_b, led_r} !== expected) begin
            $display("FAILED at %0t: {led_b, led_r} is %b, expected %b",
                     $time, {led_b, led_r}, expected);
            abort_run();
        end
    endtask

    task automatic expect_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, name, actual, expected);
            abort_run();
        end
    endtask

    function automatic int random_below(input int limit);
        return $unsigned($random(seed)) % limit;
    endfunction

    function automatic bus_addr_t ram_address(input logic [RAM_INDEX_WIDTH-1:0] index);
        bus_addr_t   address;
        logic [31:0] noise;
        noise = $random(seed);
        address.mem.region = REGION_RAM;
        address.mem.unused = noise[6:0];
        address.mem.index = index;
        address.mem.byte_offset = noise[8:7];
        return address;
    endfunction

    function automatic bus_addr_t mmio_address(input region_t region, input logic [2:0] index);
        bus_addr_t   address;
        logic [31:0] noise;
        noise = $random(seed);
        address.mmio.region = region;
        address.mmio.unused = noise[14:0];
        address.mmio.reg_index = index;
        address.mmio.byte_offset = noise[16:15];
        return address;
    endfunction

    function automatic void update_ram_model(input logic [RAM_INDEX_WIDTH-1:0] index,
                                             input logic [3:0] wstrb,
                                             input logic [31:0] wdata);
        logic [31:0] mask;
        mask = {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};
        ram_model[index] = (ram_model[index] & ~mask) | (wdata & mask);
    endfunction

    // one access, valid held through the ready cycle
    task automatic bus_access(input bus_addr_t address, input logic [3:0] wstrb,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int latency;
        int stalls;
        int expected_latency;
        latency = 0;
        stalls = 0;
        cpu_valid = 1'b1;
        cpu_address = address;
        cpu_wstrb = wstrb;
        cpu_write_data = wdata;
        do begin
            @(posedge vdp_clk);
            // loader held the ram in the cycle that just ended
            if (boot_valid && latency == stalls) begin
                stalls++;
            end
            #DRIVE_DELAY;
            latency++;
        end while (!cpu_ready);
        rdata = cpu_read_data;
        expected_latency = 1;
        // ram model follows the grant edge just passed
        if (address.mem.region == REGION_RAM) begin
            expected_latency = 1 + stalls;
            if (wstrb == 4'h0) begin
                compare_word("cpu_read_data", rdata, ram_model[address.mem.index]);
            end else begin
                update_ram_model(address.mem.index, wstrb, wdata);
            end
        end
        if (latency != expected_latency) begin
            $display("access to %h took %0d cycles to ready instead of %0d",
                     address, latency, expected_latency);
            abort_run();
        end
        // master samples ready on the edge that ends the ready cycle
        @(posedge vdp_clk);
        #DRIVE_DELAY;
        cpu_valid = 1'b0;
        cpu_wstrb = 4'h0;
        expect_flag("cpu_ready", cpu_ready, 1'b0);
    endtask

    task automatic random_ram_op();
        int          index;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
        logic [31:0] rdata;
        index = random_below(BOOT_WORDS);
        wstrb = (random_below(2) == 0) ? 4'h0 : 4'(random_below(15) + 1);
        wdata = $random(seed);
        bus_access(ram_address(RAM_INDEX_WIDTH'(index)), wstrb, wdata, rdata);
    endtask

    task automatic stream_words(input int count, input int max_gap);
        int          gap;
        logic [31:0] word;
        expect_flag("loader_busy", loader_busy, 1'b0);
        for (int i = 0; i < count; i++) begin
            gap = random_below(max_gap + 1);
            repeat (gap) begin
                @(posedge vdp_clk);
                #DRIVE_DELAY;
                expect_flag("loader_busy", loader_busy, i > 0);
            end
            word = $random(seed);
            boot_valid = 1'b1;
            boot_data = word;
            boot_last = (i == count - 1);
            @(posedge vdp_clk);
            #DRIVE_DELAY;
            expect_flag("loader_busy", loader_busy, 1'b1);
            // word landed in ram on the edge just passed
            ram_model[i] = word;
            boot_valid = 1'b0;
            boot_last = 1'b0;
        end
        @(posedge vdp_clk);
        #DRIVE_DELAY;
        expect_flag("loader_busy", loader_busy, 1'b0);
    endtask

    initial begin
        logic [31:0]        rdata;
        logic [31:0]        wdata;
        logic [31:0]        noise;
        logic [3:0]         wstrb;
        logic [3:0]         region_bits;
        logic signed [31:0] product;

        vdp_clk = 1'b0;
        vdp_reset = 1'b1;
        cpu_valid = 1'b0;
        cpu_address = '0;
        cpu_wstrb = 4'h0;
        cpu_write_data = 32'h0;
        boot_valid = 1'b0;
        boot_data = 32'h0;
        boot_last = 1'b0;
        model_status = STATUS_RESET;
        repeat (RESET_CYCLES) @(posedge vdp_clk);
        #DRIVE_DELAY;
        vdp_reset = 1'b0;

        expect_flag("cpu_ready", cpu_ready, 1'b0);
        expect_flag("loader_busy", loader_busy, 1'b0);
        check_leds(STATUS_RESET);

        // boot load, then read it all back
        stream_words(BOOT_WORDS, MAX_GAP);
        for (int i = 0; i < BOOT_WORDS; i++) begin
            bus_access(ram_address(RAM_INDEX_WIDTH'(i)), 4'h0, 32'h0, rdata);
        end

        repeat (RAM_OPS) random_ram_op();

        // second stream against cpu ram traffic
        fork
            stream_words(ARB_WORDS, MAX_GAP);
            repeat (ARB_OPS) random_ram_op();
        join
        for (int i = 0; i < BOOT_WORDS; i++) begin
            bus_access(ram_address(RAM_INDEX_WIDTH'(i)), 4'h0, 32'h0, rdata);
        end

        // multiplier, both operands set in the first round
        for (int n = 0; n < DSP_ROUNDS; n++) begin
            if (n == 0 || random_below(2) == 0) begin
                wdata = $random(seed);
                model_a = wdata[15:0];
                bus_access(mmio_address(REGION_DSP, DSP_REG_A), 4'hf, wdata, rdata);
            end
            if (n == 0 || random_below(2) == 0) begin
                wdata = $random(seed);
                model_b = wdata[15:0];
                bus_access(mmio_address(REGION_DSP, DSP_REG_B), 4'hf, wdata, rdata);
            end
            product = model_a * model_b;
            bus_access(mmio_address(REGION_DSP, DSP_REG_RESULT), 4'h0, 32'h0, rdata);
            compare_word("cpu_read_data", rdata, product);
        end

        for (int n = 0; n < STATUS_ROUNDS; n++) begin
            wdata = $random(seed);
            wstrb = 4'(random_below(15) + 1);
            model_status = wdata[1:0];
            bus_access(mmio_address(REGION_STATUS, 3'd0), wstrb, wdata, rdata);
            check_leds(model_status);
            bus_access(mmio_address(REGION_STATUS, 3'd0), 4'h0, 32'h0, rdata);
            compare_word("cpu_read_data", rdata, {30'h0, model_status});
        end

        // unmapped regions 3 to 15
        for (int n = 0; n < UNMAPPED_OPS; n++) begin
            noise = $random(seed);
            region_bits = 4'd3 + noise[3:0] % 4'd13;
            wstrb = (n % 2 == 0) ? 4'h0 : noise[7:4];
            wdata = $random(seed);
            bus_access(mmio_address(region_t'(region_bits), noise[10:8]), wstrb, wdata, rdata);
            if (wstrb == 4'h0) begin
                compare_word("cpu_read_data", rdata, 32'h0);
            end
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== verilog/address_decoder.sv ====
//////////////////////////////////////////////////
// selects are combinational and one cycle wide
// register accesses are blocked while their ready is due
// ram selects stay up until the arbiter grants them
//////////////////////////////////////////////////

module address_decoder (
    input  logic              vdp_clk,
    input  logic              vdp_reset,
    input  logic              cpu_valid,
    input  ics_pkg::bus_addr_t cpu_address,
    input  logic [3:0]        cpu_wstrb,
    output logic              ram_en,
    output logic              dsp_en,
    output logic              dsp_write_en,
    output logic              status_en,
    output logic              status_write_en,
    output logic              unmapped_en
);

    import ics_pkg::*;

    logic in_flight;
    logic access;
    logic is_write;

    assign access = cpu_valid && !in_flight;
    assign is_write = |cpu_wstrb;

    always_comb begin
        ram_en = 1'b0;
        dsp_en = 1'b0;
        status_en = 1'b0;
        unmapped_en = 1'b0;
        if (access) begin
            case (cpu_address.mem.region)
                REGION_RAM:    ram_en = 1'b1;
                REGION_DSP:    dsp_en = 1'b1;
                REGION_STATUS: status_en = 1'b1;
                default:       unmapped_en = 1'b1;
            endcase
        end
    end

    assign dsp_write_en = dsp_en && is_write;
    assign status_write_en = status_en && is_write;

    // register and unmapped accesses always finish next cycle
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            in_flight <= 1'b0;
        end else begin
            in_flight <= dsp_en || status_en || unmapped_en;
        end
    end

endmodule

// ==== verilog/boot_loader.sv ====
//////////////////////////////////////////////////
// word stream to sequential ram writes from word 0
// no back-pressure, every strobe writes that cycle
// index wraps to zero after boot_last
//////////////////////////////////////////////////

module boot_loader (
    input  logic                                vdp_clk,
    input  logic                                vdp_reset,
    input  logic                                boot_valid,
    input  logic [31:0]                         boot_data,
    input  logic                                boot_last,
    output logic                                loader_write,
    output logic [ics_pkg::RAM_INDEX_WIDTH-1:0] loader_index,
    output logic [31:0]                         loader_data,
    output logic                                loader_busy
);

    import ics_pkg::*;

    logic [RAM_INDEX_WIDTH-1:0] next_index;
    logic                       streaming;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            next_index <= '0;
            streaming <= 1'b0;
        end else if (boot_valid) begin
            next_index <= boot_last ? '0 : next_index + 1'b1;
            streaming <= !boot_last;
        end
    end

    // full word writes
    assign loader_write = boot_valid;
    assign loader_index = next_index;
    assign loader_data = boot_data;

    // high from the first strobe, low after the last write
    assign loader_busy = streaming || boot_valid;

endmodule

// ==== verilog/bus_arbiter.sv ====
//////////////////////////////////////////////////
// loader writes always win the ram port
// cpu ram accesses wait, register accesses never do
// cpu_ready is a registered one-cycle pulse
//////////////////////////////////////////////////

module bus_arbiter (
    input  logic                                vdp_clk,
    input  logic                                vdp_reset,
    input  logic                                ram_en,
    input  logic                                dsp_en,
    input  logic                                status_en,
    input  logic                                unmapped_en,
    input  ics_pkg::bus_addr_t                  cpu_address,
    input  logic [3:0]                          cpu_wstrb,
    input  logic [31:0]                         cpu_write_data,
    input  logic                                loader_write,
    input  logic [ics_pkg::RAM_INDEX_WIDTH-1:0] loader_index,
    input  logic [31:0]                         loader_data,
    input  logic [31:0]                         dsp_read_data,
    input  logic [31:0]                         status_read_data,
    output logic                                cpu_ready,
    output logic [31:0]                         cpu_read_data,
    ram_port.arbiter                            ram
);

    import ics_pkg::*;

    logic    cpu_grant;
    logic    accept;
    region_t ack_region;

    // ram select is still up in the ready cycle, so skip it there
    assign cpu_grant = ram_en && !loader_write && !cpu_ready;
    assign accept = cpu_grant || dsp_en || status_en || unmapped_en;

    always_comb begin
        if (loader_write) begin
            ram.cs = 1'b1;
            ram.address = loader_index;
            ram.wstrb = 4'hf;
            ram.write_data = loader_data;
        end else begin
            ram.cs = cpu_grant;
            ram.address = cpu_address.mem.index;
            ram.wstrb = cpu_wstrb;
            ram.write_data = cpu_write_data;
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            cpu_ready <= 1'b0;
        end else begin
            cpu_ready <= accept;
        end
    end

    // source of the access that completes next cycle
    always_ff @(posedge vdp_clk) begin
        if (accept) begin
            ack_region <= cpu_address.mem.region;
        end
    end

    always_comb begin
        case (ack_region)
            REGION_RAM:    cpu_read_data = ram.read_data;
            REGION_DSP:    cpu_read_data = dsp_read_data;
            REGION_STATUS: cpu_read_data = status_read_data;
            default:       cpu_read_data = 32'h0;
        endcase
    end

endmodule

// ==== verilog/cpu_ram.sv ====
//////////////////////////////////////////////////
// 2048 x 32 ram, byte lane write enables
// read data registered on every selected cycle
// a write returns the old word on read_data
//////////////////////////////////////////////////

module cpu_ram (
    input logic     vdp_clk,
    ram_port.memory mem
);

    import ics_pkg::*;

    logic [31:0] words [RAM_WORDS];

    always_ff @(posedge vdp_clk) begin
        if (mem.cs) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (mem.wstrb[lane]) begin
                    words[mem.address][lane*8 +: 8] <= mem.write_data[lane*8 +: 8];
                end
            end
        end
    end

    // read port
    always_ff @(posedge vdp_clk) begin
        if (mem.cs) begin
            mem.read_data <= words[mem.address];
        end
    end

endmodule

// ==== verilog/ics_core.sv ====
//////////////////////////////////////////////////
// peripheral bus top, single vdp_clk domain
// master holds valid and payload until cpu_ready
// loader stream has priority on the ram
//////////////////////////////////////////////////

module ics_core (
    input  logic                           vdp_clk,
    input  logic                           vdp_reset,

    input  logic                           cpu_valid,
    input  logic [ics_pkg::ADDR_WIDTH-1:0] cpu_address,
    input  logic [3:0]                     cpu_wstrb,
    input  logic [31:0]                    cpu_write_data,
    output logic [31:0]                    cpu_read_data,
    output logic                           cpu_ready,

    input  logic                           boot_valid,
    input  logic [31:0]                    boot_data,
    input  logic                           boot_last,

    output logic                           loader_busy,
    output logic                           led_r,
    output logic                           led_b
);

    import ics_pkg::*;

    bus_addr_t bus_address;

    logic ram_en;
    logic dsp_en;
    logic dsp_write_en;
    logic status_en;
    logic status_write_en;
    logic unmapped_en;

    logic                       loader_write;
    logic [RAM_INDEX_WIDTH-1:0] loader_index;
    logic [31:0]                loader_data;

    logic [31:0] dsp_read_data;
    logic [31:0] status_read_data;

    assign bus_address = cpu_address;

    ram_port ram_bus ();

    address_decoder u_address_decoder (
        .vdp_clk         (vdp_clk),
        .vdp_reset       (vdp_reset),
        .cpu_valid       (cpu_valid),
        .cpu_address     (bus_address),
        .cpu_wstrb       (cpu_wstrb),
        .ram_en          (ram_en),
        .dsp_en          (dsp_en),
        .dsp_write_en    (dsp_write_en),
        .status_en       (status_en),
        .status_write_en (status_write_en),
        .unmapped_en     (unmapped_en)
    );

    bus_arbiter u_bus_arbiter (
        .vdp_clk          (vdp_clk),
        .vdp_reset        (vdp_reset),
        .ram_en           (ram_en),
        .dsp_en           (dsp_en),
        .status_en        (status_en),
        .unmapped_en      (unmapped_en),
        .cpu_address      (bus_address),
        .cpu_wstrb        (cpu_wstrb),
        .cpu_write_data   (cpu_write_data),
        .loader_write     (loader_write),
        .loader_index     (loader_index),
        .loader_data      (loader_data),
        .dsp_read_data    (dsp_read_data),
        .status_read_data (status_read_data),
        .cpu_ready        (cpu_ready),
        .cpu_read_data    (cpu_read_data),
        .ram              (ram_bus.arbiter)
    );

    cpu_ram u_cpu_ram (
        .vdp_clk (vdp_clk),
        .mem     (ram_bus.memory)
    );

    mmio_regs u_mmio_regs (
        .vdp_clk          (vdp_clk),
        .vdp_reset        (vdp_reset),
        .dsp_en           (dsp_en),
        .dsp_write_en     (dsp_write_en),
        .status_en        (status_en),
        .status_write_en  (status_write_en),
        .cpu_address      (bus_address),
        .cpu_write_data   (cpu_write_data),
        .dsp_read_data    (dsp_read_data),
        .status_read_data (status_read_data),
        .led_r            (led_r),
        .led_b            (led_b)
    );

    boot_loader u_boot_loader (
        .vdp_clk      (vdp_clk),
        .vdp_reset    (vdp_reset),
        .boot_valid   (boot_valid),
        .boot_data    (boot_data),
        .boot_last    (boot_last),
        .loader_write (loader_write),
        .loader_index (loader_index),
        .loader_data  (loader_data),
        .loader_busy  (loader_busy)
    );

endmodule

// ==== verilog/ics_pkg.sv ====
//////////////////////////////////////////////////
// memory map of the peripheral bus
// top 4 address bits pick the region, all sizes fixed
// regions other than ram, dsp and status are unmapped
//////////////////////////////////////////////////

package ics_pkg;

    localparam int ADDR_WIDTH = 24;
    localparam int RAM_WORDS = 2048;
    localparam int RAM_INDEX_WIDTH = 11;

    // 4-bit region number, anything not listed reads as unmapped
    typedef enum logic [3:0] {
        REGION_RAM    = 4'd0,
        REGION_DSP    = 4'd1,
        REGION_STATUS = 4'd2
    } region_t;

    // word-addressed view for the cpu ram
    typedef struct packed {
        region_t                                  region;
        logic [ADDR_WIDTH-4-RAM_INDEX_WIDTH-3:0]  unused;
        logic [RAM_INDEX_WIDTH-1:0]               index;
        logic [1:0]                               byte_offset;
    } mem_addr_t;

    // register-addressed view for the mmio block
    typedef struct packed {
        region_t                  region;
        logic [ADDR_WIDTH-10:0]   unused;
        logic [2:0]               reg_index;
        logic [1:0]               byte_offset;
    } mmio_addr_t;

    typedef union packed {
        mem_addr_t  mem;
        mmio_addr_t mmio;
    } bus_addr_t;

    localparam logic [2:0] DSP_REG_A = 3'd0;
    localparam logic [2:0] DSP_REG_B = 3'd1;
    localparam logic [2:0] DSP_REG_RESULT = 3'd2;

    // led_r on, led_b off
    localparam logic [1:0] STATUS_RESET = 2'b01;

endpackage

// ==== verilog/mmio_regs.sv ====
//////////////////////////////////////////////////
// signed 16x16 multiplier and 2-bit led status
// product trails operand writes by one cycle
// read data captured on the select cycle
//////////////////////////////////////////////////

module mmio_regs (
    input  logic               vdp_clk,
    input  logic               vdp_reset,
    input  logic               dsp_en,
    input  logic               dsp_write_en,
    input  logic               status_en,
    input  logic               status_write_en,
    input  ics_pkg::bus_addr_t cpu_address,
    input  logic [31:0]        cpu_write_data,
    output logic [31:0]        dsp_read_data,
    output logic [31:0]        status_read_data,
    output logic               led_r,
    output logic               led_b
);

    import ics_pkg::*;

    logic signed [15:0] mult_a;
    logic signed [15:0] mult_b;
    logic signed [31:0] product;
    logic [1:0]         status;
    logic [2:0]         reg_index;

    assign reg_index = cpu_address.mmio.reg_index;

    always_ff @(posedge vdp_clk) begin
        if (dsp_write_en && reg_index == DSP_REG_A) begin
            mult_a <= cpu_write_data[15:0];
        end
        if (dsp_write_en && reg_index == DSP_REG_B) begin
            mult_b <= cpu_write_data[15:0];
        end
        product <= mult_a * mult_b;
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status <= STATUS_RESET;
        end else if (status_write_en) begin
            status <= cpu_write_data[1:0];
        end
    end

    assign led_r = status[0];
    assign led_b = status[1];

    // operands read back sign extended
    always_ff @(posedge vdp_clk) begin
        if (dsp_en) begin
            case (reg_index)
                DSP_REG_A:      dsp_read_data <= {{16{mult_a[15]}}, mult_a};
                DSP_REG_B:      dsp_read_data <= {{16{mult_b[15]}}, mult_b};
                DSP_REG_RESULT: dsp_read_data <= product;
                default:        dsp_read_data <= 32'h0;
            endcase
        end
        if (status_en) begin
            status_read_data <= {30'h0, status};
        end
    end

endmodule

// ==== verilog/ram_port.sv ====
//////////////////////////////////////////////////
// single access port of the cpu ram
// one cycle read latency, wstrb of zero is a read
//////////////////////////////////////////////////

interface ram_port;

    import ics_pkg::*;

    logic [RAM_INDEX_WIDTH-1:0] address;
    logic                       cs;
    logic [3:0]                 wstrb;
    logic [31:0]                write_data;
    logic [31:0]                read_data;

    // arbiter side owns the request
    modport arbiter (
        output address, cs, wstrb, write_data,
        input  read_data
    );

    modport memory (
        input  address, cs, wstrb, write_data,
        output read_data
    );

endinterface
